// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    // address split of a 32-bit fetch address
    parameter int tag_w    = 23;
    parameter int index_w  = 6;
    parameter int offset_w = 3;

    // two ways, one 8-byte line per way and set
    parameter int num_ways = 2;
    parameter int num_sets = 1 << index_w;

    typedef logic [31:0] word_t;
    typedef logic [63:0] line_t;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;

    // fetch address as seen by the core
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [offset_w-1:0] offset;
    } cache_addr_t;

    // tag ram word, both ways side by side
    typedef struct packed {
        tag_t tag1;
        tag_t tag0;
    } tag_entry_t;

    // data ram word, one line per way
    typedef struct packed {
        line_t line1;
        line_t line0;
    } data_entry_t;

    // one bit per way
    typedef logic [num_ways-1:0] way_mask_t;

    // byte address on the memory side
    typedef logic [63:0] mem_addr_t;

endpackage

// ==== rtl/sram_1p.sv ====
`timescale 1ns/100ps

module sram_1p #(
    parameter int  depth   = 64,
    parameter type entry_t = logic [31:0]
) (
    input  logic                         clk,
    input  logic                         cen,
    input  logic                         wen,
    input  logic [icache_pkg::index_w-1:0] addr,
    input  entry_t                       wmask,
    input  entry_t                       wdata,
    output entry_t                       rdata
);

    entry_t mem [depth];

    // one access per cycle, write has priority over read
    always_ff @(posedge clk) begin
        if (cen) begin
            if (wen) begin
                // only bits set in the mask are replaced
                mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/100ps

module icache_ctrl #(
    parameter int num_sets = icache_pkg::num_sets
) (
    input  logic                     clk,
    input  logic                     rst,
    // core side
    input  logic                     valid,
    input  icache_pkg::cache_addr_t  addr,
    output logic                     addr_ok,
    output logic                     data_ok,
    output icache_pkg::word_t        rdata,
    // memory side
    output logic                     rd_req,
    output icache_pkg::mem_addr_t    rd_addr,
    input  icache_pkg::line_t        ret_data,
    // tag ram
    output logic                     tag_cen,
    output logic                     tag_wen,
    output icache_pkg::index_t       tag_addr,
    output icache_pkg::tag_entry_t   tag_wmask,
    output icache_pkg::tag_entry_t   tag_wdata,
    input  icache_pkg::tag_entry_t   tag_rdata,
    // data ram
    output logic                     data_cen,
    output logic                     data_wen,
    output icache_pkg::index_t       data_addr,
    output icache_pkg::data_entry_t  data_wmask,
    output icache_pkg::data_entry_t  data_wdata,
    input  icache_pkg::data_entry_t  data_rdata
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } state_e;

    state_e state;
    state_e next_state;

    // request buffer
    cache_addr_t req_q;

    // miss buffer
    line_t miss_line_q;

    // per-set valid bits and round-robin pointer
    way_mask_t valid_q [num_sets];
    logic      rr_q    [num_sets];

    logic      accept;
    logic      cache_hit;
    way_mask_t set_valid;
    way_mask_t hit_way;
    way_mask_t victim;
    line_t     hit_line;
    word_t     hit_word;
    word_t     miss_word;

    logic [$bits(cache_addr_t)-1:0] line_addr;

    // pick the 32-bit word addressed by offset bit 2
    function automatic word_t select_word(line_t line, logic upper);
        if (upper) begin
            return line[63:32];
        end
        return line[31:0];
    endfunction

    assign accept = (state == IDLE) && valid;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (cache_hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = MISS;
                end
            end
            MISS: begin
                next_state = REFILL;
            end
            REFILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= addr;
        end
    end

    // memory answers in the request cycle
    always_ff @(posedge clk) begin
        if (state == MISS) begin
            miss_line_q <= ret_data;
        end
    end

    // tag compare, ram output is valid during LOOKUP
    assign set_valid  = valid_q[req_q.index];
    assign hit_way[0] = set_valid[0] && (tag_rdata.tag0 == req_q.tag);
    assign hit_way[1] = set_valid[1] && (tag_rdata.tag1 == req_q.tag);
    assign cache_hit  = |hit_way;

    assign hit_line  = hit_way[1] ? data_rdata.line1 : data_rdata.line0;
    assign hit_word  = select_word(hit_line, req_q.offset[2]);
    assign miss_word = select_word(miss_line_q, req_q.offset[2]);

    // invalid way first, otherwise follow the set's round-robin bit
    always_comb begin
        if (!set_valid[0]) begin
            victim = 2'b01;
        end else if (!set_valid[1]) begin
            victim = 2'b10;
        end else if (rr_q[req_q.index]) begin
            victim = 2'b10;
        end else begin
            victim = 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_sets; i++) begin
                valid_q[i] <= '0;
                rr_q[i]    <= 1'b0;
            end
        end else if (state == REFILL) begin
            valid_q[req_q.index] <= set_valid | victim;
            rr_q[req_q.index]    <= ~rr_q[req_q.index];
        end
    end

    // both rams: read on accept with the incoming index, write on refill
    assign tag_cen  = accept || (state == REFILL);
    assign tag_wen  = (state == REFILL);
    assign tag_addr = (state == REFILL) ? req_q.index : addr.index;

    assign data_cen  = tag_cen;
    assign data_wen  = tag_wen;
    assign data_addr = tag_addr;

    assign tag_wdata = '{tag1: req_q.tag, tag0: req_q.tag};
    assign tag_wmask = '{tag1: {tag_w{victim[1]}}, tag0: {tag_w{victim[0]}}};

    assign data_wdata = '{line1: miss_line_q, line0: miss_line_q};
    assign data_wmask = '{
        line1: {$bits(line_t){victim[1]}},
        line0: {$bits(line_t){victim[0]}}
    };

    // core outputs
    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && cache_hit) || (state == REFILL);
    assign rdata   = (state == REFILL) ? miss_word : hit_word;

    // one line read per miss, line aligned
    assign line_addr = {req_q.tag, req_q.index, {offset_w{1'b0}}};
    assign rd_req    = (state == MISS);
    assign rd_addr   = mem_addr_t'(line_addr);

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/100ps

module icache #(
    parameter int num_sets = icache_pkg::num_sets
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  icache_pkg::cache_addr_t addr,
    output logic                    addr_ok,
    output logic                    data_ok,
    output icache_pkg::word_t       rdata,
    output logic                    rd_req,
    output icache_pkg::mem_addr_t   rd_addr,
    input  icache_pkg::line_t       ret_data
);

    import icache_pkg::*;

    logic        tag_cen;
    logic        tag_wen;
    index_t      tag_addr;
    tag_entry_t  tag_wmask;
    tag_entry_t  tag_wdata;
    tag_entry_t  tag_rdata;

    logic        data_cen;
    logic        data_wen;
    index_t      data_addr;
    data_entry_t data_wmask;
    data_entry_t data_wdata;
    data_entry_t data_rdata;

    icache_ctrl #(
        .num_sets (num_sets)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .addr       (addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .ret_data   (ret_data),
        .tag_cen    (tag_cen),
        .tag_wen    (tag_wen),
        .tag_addr   (tag_addr),
        .tag_wmask  (tag_wmask),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .data_cen   (data_cen),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wmask (data_wmask),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

    // tags of both ways in one word
    sram_1p #(
        .depth   (num_sets),
        .entry_t (tag_entry_t)
    ) u_tag_ram (
        .clk   (clk),
        .cen   (tag_cen),
        .wen   (tag_wen),
        .addr  (tag_addr),
        .wmask (tag_wmask),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    // lines of both ways in one word
    sram_1p #(
        .depth   (num_sets),
        .entry_t (data_entry_t)
    ) u_data_ram (
        .clk   (clk),
        .cen   (data_cen),
        .wen   (data_wen),
        .addr  (data_addr),
        .wmask (data_wmask),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

// ==== testbench/icache_assertions.sv ====
`timescale 1ns/100ps

module icache_assertions (
    input logic clk,
    input logic rst,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req
);

    // a result never shows up while the cache is idle
    property no_ok_overlap;
        @(posedge clk) disable iff (rst)
            !(addr_ok && data_ok);
    endproperty

    // single-beat line read
    property rd_req_single_cycle;
        @(posedge clk) disable iff (rst)
            rd_req |=> !rd_req;
    endproperty

    // refill returns the word right after the memory read
    property rd_req_then_data_ok;
        @(posedge clk) disable iff (rst)
            rd_req |=> data_ok;
    endproperty

    no_ok_overlap_a: assert property (no_ok_overlap)
        else $error("addr_ok and data_ok high in the same cycle");

    rd_req_single_cycle_a: assert property (rd_req_single_cycle)
        else $error("rd_req held for more than one cycle");

    rd_req_then_data_ok_a: assert property (rd_req_then_data_ok)
        else $error("data_ok did not follow rd_req");

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

    import icache_pkg::*;

    localparam int max_wait = 20;

    logic        clk;
    logic        rst;
    logic        valid;
    cache_addr_t addr;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_addr_t   rd_addr;
    line_t       ret_data;

    // shadow of the cache contents per set and way
    tag_t sh_tag   [num_sets][num_ways];
    logic sh_valid [num_sets][num_ways];
    logic sh_rr    [num_sets];

    icache #(
        .num_sets (num_sets)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .addr     (addr),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    bind icache_ctrl icache_assertions u_assertions (
        .clk     (clk),
        .rst     (rst),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rd_req  (rd_req)
    );

    always #5 clk = ~clk;

    // fixed hash of a word's byte address
    function automatic word_t hash_word(mem_addr_t a);
        word_t x;
        x = a[31:0] ^ a[63:32] ^ 32'h3c6e_f372;
        x = x * 32'h9e37_79b1;
        return x ^ (x >> 15);
    endfunction

    // memory answers in the same cycle
    always_comb begin
        ret_data = {hash_word(rd_addr + 64'd4), hash_word(rd_addr)};
    end

    function automatic mem_addr_t line_address(cache_addr_t a);
        mem_addr_t la;
        la = '0;
        la[31:0] = {a.tag, a.index, 3'b000};
        return la;
    endfunction

    function automatic word_t expected_word(cache_addr_t a);
        mem_addr_t wa;
        wa = '0;
        wa[31:0] = {a.tag, a.index, a.offset[2], 2'b00};
        return hash_word(wa);
    endfunction

    function automatic cache_addr_t make_addr(tag_t tag, index_t index, logic [2:0] offset);
        cache_addr_t a;
        a.tag = tag;
        a.index = index;
        a.offset = offset;
        return a;
    endfunction

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: no %s from the cache", $time, what);
        stop_on_failure();
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic model_clear();
        for (int s = 0; s < num_sets; s++) begin
            sh_valid[s][0] = 1'b0;
            sh_valid[s][1] = 1'b0;
            sh_rr[s] = 1'b0;
        end
    endtask

    function automatic logic model_is_hit(cache_addr_t a);
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[a.index][w] && sh_tag[a.index][w] == a.tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // invalid way first, then the set's round-robin bit
    task automatic model_fill(input cache_addr_t a);
        int way;
        if (!sh_valid[a.index][0]) begin
            way = 0;
        end else if (!sh_valid[a.index][1]) begin
            way = 1;
        end else begin
            way = sh_rr[a.index] ? 1 : 0;
        end
        sh_tag[a.index][way] = a.tag;
        sh_valid[a.index][way] = 1'b1;
        sh_rr[a.index] = ~sh_rr[a.index];
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        valid = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        model_clear();
        check_flag("addr_ok after reset", addr_ok, 1'b1);
        check_flag("data_ok after reset", data_ok, 1'b0);
        check_flag("rd_req after reset", rd_req, 1'b0);
    endtask

    // one request with its memory read count and data_ok latency
    task automatic issue_read(input cache_addr_t a, output int misses, output int latency);
        int waited;
        waited = 0;
        misses = 0;
        @(negedge clk);
        valid = 1'b1;
        addr = a;
        while (!addr_ok) begin
            @(negedge clk);
            waited++;
            if (waited > max_wait) begin
                report_timeout("addr_ok");
            end
        end
        // taken at the next rising edge
        @(negedge clk);
        valid = 1'b0;
        latency = 1;
        while (!data_ok) begin
            if (rd_req) begin
                misses++;
                check_addr("rd_addr", rd_addr, line_address(a));
            end
            @(negedge clk);
            latency++;
            if (latency > max_wait) begin
                report_timeout("data_ok");
            end
        end
        // a memory read alongside data_ok still counts
        if (rd_req) begin
            misses++;
        end
        check_word("rdata", rdata, expected_word(a));
    endtask

    task automatic read_and_check(input cache_addr_t a, input logic exp_miss);
        int misses;
        int latency;
        issue_read(a, misses, latency);
        check_count("rd_req pulses", misses, exp_miss ? 1 : 0);
        check_count("data_ok latency", latency, exp_miss ? 3 : 1);
        if (exp_miss) begin
            model_fill(a);
        end
    endtask

    task automatic test_first_miss();
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd0), 1'b1);
    endtask

    task automatic test_hits();
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd0), 1'b0);
        // other word of the same line
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd4), 1'b0);
    endtask

    task automatic test_two_way_fill();
        read_and_check(make_addr(23'h00_0aaa, 6'd9, 3'd0), 1'b1);
        read_and_check(make_addr(23'h15_5555, 6'd9, 3'd4), 1'b1);
        read_and_check(make_addr(23'h00_0aaa, 6'd9, 3'd4), 1'b0);
        read_and_check(make_addr(23'h15_5555, 6'd9, 3'd0), 1'b0);
    endtask

    task automatic test_eviction();
        // way 0 holds the older line
        read_and_check(make_addr(23'h70_0f0f, 6'd9, 3'd0), 1'b1);
        read_and_check(make_addr(23'h15_5555, 6'd9, 3'd0), 1'b0);
        read_and_check(make_addr(23'h00_0aaa, 6'd9, 3'd0), 1'b1);
    endtask

    task automatic test_random_traffic();
        tag_t        pool [4];
        cache_addr_t a;
        pool[0] = 23'h00_1111;
        pool[1] = 23'h2a_0002;
        pool[2] = 23'h13_3c3c;
        pool[3] = 23'h7f_fff0;
        // sets 16 to 19 stay clear of the directed tests
        for (int i = 0; i < 200; i++) begin
            a.tag = pool[$urandom_range(3, 0)];
            a.index = index_t'(16 + $urandom_range(3, 0));
            a.offset = 3'($urandom_range(7, 0));
            read_and_check(a, !model_is_hit(a));
        end
    endtask

    task automatic test_reset_flush();
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd4), 1'b0);
        apply_reset();
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd4), 1'b1);
        read_and_check(make_addr(23'h01_2345, 6'd5, 3'd0), 1'b0);
    endtask

    initial begin
        void'($urandom(32'h7966_9949));
        clk = 1'b0;
        rst = 1'b1;
        valid = 1'b0;
        addr = '0;
        model_clear();
        apply_reset();
        test_first_miss();
        test_hits();
        test_two_way_fill();
        test_eviction();
        test_random_traffic();
        test_reset_flush();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/icache_pkg.sv
rtl/sram_1p.sv
rtl/icache_ctrl.sv
rtl/icache.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - rtl/icache_pkg.sv
      - rtl/sram_1p.sv
      - rtl/icache_ctrl.sv
      - rtl/icache.sv
  - target: test
    files:
      - testbench/icache_assertions.sv
      - testbench/icache_tb.sv
